//--- Bender.yml
package:
  name: instr_decoder

sources:
  - include_dirs:
      - include
    files:
      - verilog/deco_pkg.sv
      - verilog/ea_decode.sv
      - verilog/opcode_class.sv
      - verilog/decode_reg.sv
      - verilog/instr_decoder.sv
  - target: simulation
    files:
      - sim/tb_instr_decoder.sv

//--- include/deco_defines.svh
`ifndef DECO_DEFINES_SVH
`define DECO_DEFINES_SVH

// modrm byte layout
`define MOD_W 2
`define RM_W 3

// mod value for register operands
`define MOD_REG 2'b11

// rm code that means a plain 16-bit address when mod is 00
`define RM_DIRECT 3'b110

// segment codes in es cs ss ds order
`define SEG_DEFAULT 2'b11
`define SEG_STACK 2'b10

`endif

//--- sim/tb_instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_instr_decoder;

        import deco_pkg::*;

        localparam int ITEMS = 200;   // random items per test
        localparam int NUM_TESTS = 5;
        localparam int TIMEOUT_NS = (16 + NUM_TESTS * ITEMS + 100) * 20;

        logic     clk;
        logic     reset;
        logic     op_valid;
        logic [7:0] op;
        logic [7:0] modrm;
        seg_ovr_t sovr;
        logic     dec_valid;
        deco_t    dec;

        logic [31:0] rng_state;
        logic        exp_valid;
        deco_t       held;        // record the DUT should show now
        int          errors;
        int          checks;
        int          test_errors;
        int          test_checks;

        instr_decoder i_instr_decoder
        (
                .clk       (clk),
                .reset     (reset),
                .op_valid  (op_valid),
                .op        (op),
                .modrm     (modrm),
                .sovr      (sovr),
                .dec_valid (dec_valid),
                .dec       (dec)
        );

        initial
        begin
                clk = 1'b0;
                forever
                        #10 clk = ~clk;
        end

        function automatic logic [31:0] next_rand();
                rng_state = rng_state * 32'd1664525 + 32'd1013904223;
                return rng_state;
        endfunction

        // reference decode from the opcode map
        function automatic deco_t expected_decode(input logic [7:0] o, input logic [7:0] m,
                                                  input seg_ovr_t s);
                deco_t      e;
                logic [1:0] md;
                logic [2:0] rg;
                logic [2:0] rmv;
                logic       direct;

                md = m[7:6];
                rg = m[5:3];
                rmv = m[2:0];
                direct = (md == 2'b00) && (rmv == 3'd6);
                e = '0;
                e.cls = cls_hlt;
                if ((o <= 8'h3f && !o[2]) || (o >= 8'h88 && o <= 8'h8b))
                begin
                        e.cls = o[7] ? cls_mov : cls_alu;
                        e.alu_op = o[7] ? alu_add : alu_op_t'(o[5:3]);
                        e.is_word = o[0];
                        e.need_modrm = 1'b1;
                        e.form = (md == 2'b11) ? form_rr : (o[1] ? form_mr : form_rm);
                        e.dst = gpr_t'(o[1] ? rg : rmv);
                        e.src = gpr_t'(o[1] ? rmv : rg);
                end
                else if (o <= 8'h3f && o[2:1] == 2'b10)
                begin
                        e.cls = cls_alu;
                        e.alu_op = alu_op_t'(o[5:3]);
                        e.is_word = o[0];
                        e.form = form_ir;
                        e.need_imm = 1'b1;
                        e.imm_size = o[0];
                end
                else if (o >= 8'h80 && o <= 8'h83)
                begin
                        e.cls = cls_alu;
                        e.alu_op = alu_op_t'(rg);
                        e.is_word = o[0];
                        e.need_modrm = 1'b1;
                        e.form = (md == 2'b11) ? form_ir : form_im;
                        e.need_imm = 1'b1;
                        e.imm_size = (o == 8'h81);
                        e.dst = gpr_t'(rmv);
                end
                else if (o >= 8'h40 && o <= 8'h5f)
                begin
                        case (o[4:3])
                                2'd0: e.cls = cls_inc;
                                2'd1: e.cls = cls_dec;
                                2'd2: e.cls = cls_push;
                                default: e.cls = cls_pop;
                        endcase
                        e.is_word = o[0];
                        if (o[4:3] == 2'd3)
                                e.dst = gpr_t'(o[2:0]);
                        else
                                e.src = gpr_t'(o[2:0]);
                end
                else if (o >= 8'hb0 && o <= 8'hbf)
                begin
                        e.cls = cls_mov;
                        e.form = form_ir;
                        e.is_word = o[3];
                        e.need_imm = 1'b1;
                        e.imm_size = o[3];
                        e.dst = gpr_t'(o[2:0]);
                end
                else if (o == 8'h90)
                        e.cls = cls_nop;
                e.ea = '{base: ea_none, index: ea_none, seg: seg_ds};
                if (e.need_modrm && md != 2'b11)
                begin
                        case (rmv)
                                3'd0: e.ea = '{base: ea_bx, index: ea_si, seg: seg_ds};
                                3'd1: e.ea = '{base: ea_bx, index: ea_di, seg: seg_ds};
                                3'd2: e.ea = '{base: ea_bp, index: ea_si, seg: seg_ds};
                                3'd3: e.ea = '{base: ea_bp, index: ea_di, seg: seg_ds};
                                3'd4: e.ea = '{base: ea_none, index: ea_si, seg: seg_ds};
                                3'd5: e.ea = '{base: ea_none, index: ea_di, seg: seg_ds};
                                3'd6: e.ea = '{base: direct ? ea_none : ea_bp, index: ea_none,
                                               seg: seg_ds};
                                default: e.ea = '{base: ea_bx, index: ea_none, seg: seg_ds};
                        endcase
                        if (s.valid)
                                e.ea.seg = s.seg;
                        else if (e.ea.base == ea_bp)
                                e.ea.seg = seg_ss;
                        e.need_off = (md == 2'b01) || (md == 2'b10) || direct;
                        e.off_size = (md == 2'b10) || direct;
                end
                return e;
        endfunction

        task automatic check_value(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
                checks++;
                test_checks++;
                if (act !== exp)
                begin
                        $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
                        errors++;
                        test_errors++;
                end
        endtask

        // apply one item and check the one captured on the same edge
        task automatic apply_item(input logic v, input logic [7:0] o, input logic [7:0] m,
                                  input seg_ovr_t s);
                @(posedge clk);
                op_valid <= v;
                op <= o;
                modrm <= m;
                sovr <= s;
                @(negedge clk);
                check_value("dec_valid", exp_valid, dec_valid);
                check_value("dec", held, dec);
                exp_valid = v;
                if (v)
                        held = expected_decode(o, m, s);
        endtask

        task automatic finish_test(input int num, input string name);
                $display("test %0d %s: %0d checks, %0d errors", num, name, test_checks,
                         test_errors);
                test_checks = 0;
                test_errors = 0;
        endtask

        initial
        begin
                #(TIMEOUT_NS);
                $display("watchdog expired before the decode stream finished");
                $display("Simulation FAILED");
                $finish;
        end

        initial
        begin
                logic [31:0] r;
                logic [7:0]  o;

                reset = 1'b1;
                op_valid = 1'b0;
                op = 8'h00;
                modrm = 8'h00;
                sovr = '0;
                rng_state = 32'h07bbcad5;
                exp_valid = 1'b0;
                held = '0;
                errors = 0;
                checks = 0;
                test_errors = 0;
                test_checks = 0;
                repeat (16) @(posedge clk);
                reset <= 1'b0;

                for (int i = 0; i < 8; i++)
                begin
                        r = next_rand();
                        apply_item(1'b0, r[31:24], r[23:16], seg_ovr_t'(r[15:13]));
                end
                finish_test(1, "idle after reset");

                for (int i = 0; i < ITEMS; i++)
                begin
                        r = next_rand();
                        if (r[31:29] == 3'd0)
                                o = {6'b100010, r[28:27]};   // some mov r/m
                        else
                                o = {2'b00, r[28:26], 1'b0, r[25:24]};
                        apply_item(1'b1, o, r[23:16], seg_ovr_t'(3'b000));
                end
                finish_test(2, "alu register/memory");

                for (int i = 0; i < ITEMS; i++)
                begin
                        r = next_rand();
                        if (r[31])
                                o = {6'b100000, r[25:24]};
                        else
                                o = {2'b00, r[28:26], 2'b10, r[24]};
                        apply_item(1'b1, o, r[23:16], seg_ovr_t'(r[15:13]));
                end
                finish_test(3, "immediate group and accumulator");

                for (int i = 0; i < ITEMS; i++)
                begin
                        r = next_rand();
                        case (r[31:30])
                                2'd1: o = {6'b100010, r[25:24]};
                                2'd2: o = {6'b100000, r[25:24]};
                                default: o = {2'b00, r[28:26], 1'b0, r[25:24]};
                        endcase
                        apply_item(r[12:10] != 3'd0, o, r[23:16], seg_ovr_t'(r[15:13]));
                end
                finish_test(4, "effective address");

                for (int i = 0; i < ITEMS; i++)
                begin
                        r = next_rand();
                        case (r[31:30])
                                2'd0: o = {3'b010, r[28:24]};   // inc dec push pop
                                2'd1: o = {4'hb, r[27:24]};
                                2'd2: o = r[29] ? 8'h90 : r[28:21];
                                default: o = r[28:21];
                        endcase
                        apply_item(1'b1, o, r[20:13], seg_ovr_t'(r[12:10]));
                end
                apply_item(1'b0, 8'h00, 8'h00, seg_ovr_t'(3'b000));   // drain last item
                finish_test(5, "register, mov immediate, nop, hlt");

                $display("total: %0d checks, %0d errors", checks, errors);
                if (errors == 0)
                        $display("Simulation PASSED");
                else
                        $display("Simulation FAILED");
                $finish;
        end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
verilog/deco_pkg.sv
verilog/ea_decode.sv
verilog/opcode_class.sv
verilog/decode_reg.sv
verilog/instr_decoder.sv
sim/tb_instr_decoder.sv

//--- verilog/deco_pkg.sv
`default_nettype none

package deco_pkg;

        typedef enum logic [2:0] {
                cls_alu, cls_mov, cls_inc, cls_dec,
                cls_push, cls_pop, cls_nop, cls_hlt
        } instr_class_t;

        // x86 order as in opcode bits 5:3
        typedef enum logic [2:0] {
                alu_add, alu_or, alu_adc, alu_sbb,
                alu_and, alu_sub, alu_xor, alu_cmp
        } alu_op_t;

        typedef enum logic [2:0] {
                form_none, form_rr, form_rm, form_mr, form_ir, form_im
        } op_form_t;

        typedef enum logic [2:0] {
                gpr_ax, gpr_cx, gpr_dx, gpr_bx, gpr_sp, gpr_bp, gpr_si, gpr_di
        } gpr_t;

        typedef enum logic [3:0] {
                ea_ax, ea_cx, ea_dx, ea_bx, ea_sp, ea_bp, ea_si, ea_di,
                ea_none = 4'b1100
        } ea_reg_t;

        typedef enum logic [1:0] {
                seg_es, seg_cs, seg_ss, seg_ds
        } seg_t;

        typedef struct packed {
                logic valid;
                seg_t seg;
        } seg_ovr_t;

        typedef struct packed {
                ea_reg_t base;
                ea_reg_t index;
                seg_t    seg;
        } ea_t;

        typedef struct packed {
                instr_class_t cls;
                alu_op_t      alu_op;
                op_form_t     form;
                logic         is_word;
                logic         need_modrm;
                logic         need_off;
                logic         off_size;   // 1 = 16-bit displacement
                logic         need_imm;
                logic         imm_size;   // 1 = 16-bit immediate
                gpr_t         src;
                gpr_t         dst;
                ea_t          ea;
        } deco_t;

endpackage

`default_nettype wire

//--- verilog/decode_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "deco_defines.svh"

module decode_reg
(
        input  wire logic            clk,
        input  wire logic            reset,
        input  wire logic            op_valid,
        input  wire deco_pkg::deco_t fields,
        input  wire deco_pkg::ea_t   ea,
        input  wire logic            need_off_mod,
        input  wire logic            off_size_mod,
        output logic                 dec_valid,
        output deco_pkg::deco_t      dec
);

        import deco_pkg::*;

        logic  use_ea;
        deco_t merged;

        // memory operand present
        assign use_ea = fields.need_modrm && (fields.form != form_rr);

        always_comb
        begin
                merged = fields;
                merged.need_off = use_ea && need_off_mod;
                merged.off_size = use_ea && off_size_mod;
                if (use_ea)
                        merged.ea = ea;
                else
                        merged.ea = '{base: ea_none, index: ea_none, seg: seg_t'(`SEG_DEFAULT)};
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        dec_valid <= 1'b0;
                        dec <= '0;
                end
                else
                begin
                        dec_valid <= op_valid;
                        if (op_valid)
                                dec <= merged;   // holds otherwise
                end
        end

        // disp16 only ever comes with a displacement
        off_size_needs_off: assert property (@(posedge clk) disable iff (reset)
                op_valid |-> (!off_size_mod || need_off_mod))
                else $error("decode_reg: disp16 size without displacement");

        // a memory form must bring a modrm byte or the address is lost
        mem_form_needs_modrm: assert property (@(posedge clk) disable iff (reset)
                op_valid && (fields.form == form_rm || fields.form == form_mr
                        || fields.form == form_im) |-> fields.need_modrm)
                else $error("decode_reg: memory operand form without modrm");

endmodule

`default_nettype wire

//--- verilog/ea_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "deco_defines.svh"

module ea_decode
(
        input  wire logic [`MOD_W-1:0] mod_f,
        input  wire logic [`RM_W-1:0]  rm,
        input  wire deco_pkg::seg_ovr_t sovr,
        output deco_pkg::ea_t           ea,
        output logic                    need_off_mod,
        output logic                    off_size_mod
);

        import deco_pkg::*;

        ea_reg_t base;
        ea_reg_t index;
        logic    mod_reg;
        logic    direct;

        assign mod_reg = (mod_f == `MOD_REG);
        assign direct = (mod_f == 2'b00) && (rm == `RM_DIRECT);

        always_comb
        begin
                case (rm)
                        3'd0, 3'd1, 3'd7: base = ea_bx;
                        3'd2, 3'd3:       base = ea_bp;
                        3'd6:             base = direct ? ea_none : ea_bp;
                        default:          base = ea_none;   // si or di alone
                endcase
        end

        always_comb
        begin
                case (rm)
                        3'd0, 3'd2, 3'd4: index = ea_si;
                        3'd1, 3'd3, 3'd5: index = ea_di;
                        default:          index = ea_none;
                endcase
        end

        assign ea.base = mod_reg ? ea_none : base;
        assign ea.index = mod_reg ? ea_none : index;

        always_comb
        begin
                if (mod_reg)
                        ea.seg = seg_t'(`SEG_DEFAULT);
                else if (sovr.valid)
                        ea.seg = sovr.seg;
                else if (base == ea_bp)
                        ea.seg = seg_t'(`SEG_STACK);   // bp based goes to stack
                else
                        ea.seg = seg_t'(`SEG_DEFAULT);
        end

        assign need_off_mod = (mod_f == 2'b01) || (mod_f == 2'b10) || direct;
        assign off_size_mod = (mod_f == 2'b10) || direct;   // disp16

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "deco_defines.svh"

module instr_decoder
(
        input  wire logic               clk,
        input  wire logic               reset,
        input  wire logic               op_valid,
        input  wire logic [7:0]         op,
        input  wire logic [7:0]         modrm,
        input  wire deco_pkg::seg_ovr_t sovr,
        output logic                    dec_valid,
        output deco_pkg::deco_t         dec
);

        import deco_pkg::*;

        logic [`MOD_W-1:0] mod_f;
        logic [`RM_W-1:0]  rm;
        deco_t             fields;
        ea_t               ea;
        logic              need_off_mod;
        logic              off_size_mod;

        assign mod_f = modrm[7:6];
        assign rm = modrm[`RM_W-1:0];

        opcode_class i_opcode_class
        (
                .op     (op),
                .modrm  (modrm),
                .fields (fields)
        );

        ea_decode i_ea_decode
        (
                .mod_f        (mod_f),
                .rm           (rm),
                .sovr         (sovr),
                .ea           (ea),
                .need_off_mod (need_off_mod),
                .off_size_mod (off_size_mod)
        );

        decode_reg i_decode_reg
        (
                .clk          (clk),
                .reset        (reset),
                .op_valid     (op_valid),
                .fields       (fields),
                .ea           (ea),
                .need_off_mod (need_off_mod),
                .off_size_mod (off_size_mod),
                .dec_valid    (dec_valid),
                .dec          (dec)
        );

endmodule

`default_nettype wire

//--- verilog/opcode_class.sv
`timescale 1ns/1ps
`default_nettype none
`include "deco_defines.svh"

module opcode_class
(
        input  wire logic [7:0] op,
        input  wire logic [7:0] modrm,
        output deco_pkg::deco_t fields
);

        import deco_pkg::*;

        logic     mod_reg;
        logic     d;
        gpr_t     reg_g;
        gpr_t     rm_g;
        gpr_t     op_g;
        op_form_t rm_form;
        gpr_t     rm_src;
        gpr_t     rm_dst;

        assign mod_reg = (modrm[7:6] == `MOD_REG);
        assign d = op[1];   // direction bit
        assign reg_g = gpr_t'(modrm[5:3]);
        assign rm_g = gpr_t'(modrm[`RM_W-1:0]);
        assign op_g = gpr_t'(op[2:0]);   // register in opcode

        // shared by alu and mov register/memory forms
        assign rm_form = mod_reg ? form_rr : (d ? form_mr : form_rm);
        assign rm_dst = d ? reg_g : rm_g;
        assign rm_src = d ? rm_g : reg_g;

        always_comb
        begin
                fields = '0;
                fields.cls = cls_hlt;
                fields.alu_op = alu_add;
                fields.form = form_none;
                fields.src = gpr_ax;
                fields.dst = gpr_ax;
                fields.is_word = op[0];
                unique casez (op)
                        8'b00??_?0??:   // alu r/m
                        begin
                                fields.cls = cls_alu;
                                fields.alu_op = alu_op_t'(op[5:3]);
                                fields.form = rm_form;
                                fields.need_modrm = 1'b1;
                                fields.src = rm_src;
                                fields.dst = rm_dst;
                        end
                        8'b00??_?10?:   // alu acc, imm
                        begin
                                fields.cls = cls_alu;
                                fields.alu_op = alu_op_t'(op[5:3]);
                                fields.form = form_ir;
                                fields.need_imm = 1'b1;
                                fields.imm_size = op[0];
                        end
                        8'b1000_00??:   // immediate group
                        begin
                                fields.cls = cls_alu;
                                fields.alu_op = alu_op_t'(modrm[5:3]);
                                fields.form = mod_reg ? form_ir : form_im;
                                fields.need_modrm = 1'b1;
                                fields.need_imm = 1'b1;
                                fields.imm_size = (op[1:0] == 2'b01);   // only 81h
                                fields.dst = rm_g;
                        end
                        8'b1000_10??:   // mov r/m
                        begin
                                fields.cls = cls_mov;
                                fields.form = rm_form;
                                fields.need_modrm = 1'b1;
                                fields.src = rm_src;
                                fields.dst = rm_dst;
                        end
                        8'b0100_0???:
                        begin
                                fields.cls = cls_inc;
                                fields.src = op_g;
                        end
                        8'b0100_1???:
                        begin
                                fields.cls = cls_dec;
                                fields.src = op_g;
                        end
                        8'b0101_0???:
                        begin
                                fields.cls = cls_push;
                                fields.src = op_g;
                        end
                        8'b0101_1???:
                        begin
                                fields.cls = cls_pop;
                                fields.dst = op_g;
                        end
                        8'b1001_0000:
                        begin
                                fields.cls = cls_nop;
                                fields.is_word = 1'b0;
                        end
                        8'b1011_????:   // mov reg, imm
                        begin
                                fields.cls = cls_mov;
                                fields.form = form_ir;
                                fields.is_word = op[3];
                                fields.need_imm = 1'b1;
                                fields.imm_size = op[3];
                                fields.dst = op_g;
                        end
                        default:
                                fields.is_word = 1'b0;   // unknown opcode stays hlt
                endcase
        end

endmodule

`default_nettype wire
